//--- dual_uart_rx.f
rtl/dual_uart_pkg.sv
rtl/oversample_tick.sv
rtl/uart_rx_channel.sv
rtl/rx_merge.sv
rtl/dual_uart_rx_top.sv
dv/tb_dual_uart_rx.sv

//--- dv/tb_dual_uart_rx.sv
`timescale 1ns/100ps

module tb_dual_uart_rx;

    localparam int bit_cycles = dual_uart_pkg::div_counter * dual_uart_pkg::oversample;
    localparam int frame_bits = dual_uart_pkg::data_bits + 2;  // Start bit, data bits and stop bit
    localparam int num_random = 200;                           // Random frames per line
    localparam int num_frames = 7 + 2 * num_random;            // Directed plus random
    localparam real clk_period = 4.0;
    localparam longint timeout_ns = 2 * num_frames * frame_bits * bit_cycles * 4;

    logic                                clk;
    logic                                reset;
    logic                                rx_line0;
    logic                                rx_line1;
    logic                                byte_valid;
    logic [dual_uart_pkg::data_bits-1:0] byte_data;
    logic                                byte_channel;
    logic                                frame_error;

    logic [dual_uart_pkg::data_bits:0] exp_q0[$];  // Top bit set for a framing error
    logic [dual_uart_pkg::data_bits:0] exp_q1[$];

    integer seed = 32'h85d736b8;
    int kind_errors  = 0;
    int data_errors  = 0;
    int order_errors = 0;
    int other_errors = 0;
    int cycle_count  = 0;
    int last_cycle0  = 0;  // Cycle of the latest channel 0 event
    int last_cycle1  = 0;

    logic [dual_uart_pkg::data_bits-1:0] rand_data0[num_random];
    logic [dual_uart_pkg::data_bits-1:0] rand_data1[num_random];
    int rand_gap0[num_random];
    int rand_gap1[num_random];

    dual_uart_rx_top dut0 (
        .clk          (clk),
        .reset        (reset),
        .rx_line0     (rx_line0),
        .rx_line1     (rx_line1),
        .byte_valid   (byte_valid),
        .byte_data    (byte_data),
        .byte_channel (byte_channel),
        .frame_error  (frame_error)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    always @(posedge clk) cycle_count <= cycle_count + 1;

    // A good stop bit gives the byte and a low one gives a framing error with no data
    function automatic logic [dual_uart_pkg::data_bits:0] expected_event(
        input logic [dual_uart_pkg::data_bits-1:0] data,
        input logic                                stop_bit
    );
        if (stop_bit) begin
            return {1'b0, data};
        end
        return {1'b1, {dual_uart_pkg::data_bits{1'b0}}};
    endfunction

    task automatic drive_line0(input logic [dual_uart_pkg::data_bits-1:0] data,
                               input logic stop_bit, input int offset);
        logic [frame_bits-1:0] frame;
        frame = {stop_bit, data, 1'b0};                  // Sent from bit 0 upward so the LSB leads
        exp_q0.push_back(expected_event(data, stop_bit));
        repeat (offset) @(negedge clk);
        for (int i = 0; i < frame_bits; i++) begin
            rx_line0 = frame[i];
            repeat (bit_cycles) @(negedge clk);
        end
        rx_line0 = 1'b1;
    endtask

    task automatic drive_line1(input logic [dual_uart_pkg::data_bits-1:0] data,
                               input logic stop_bit, input int offset);
        logic [frame_bits-1:0] frame;
        frame = {stop_bit, data, 1'b0};
        exp_q1.push_back(expected_event(data, stop_bit));
        repeat (offset) @(negedge clk);
        for (int i = 0; i < frame_bits; i++) begin
            rx_line1 = frame[i];
            repeat (bit_cycles) @(negedge clk);
        end
        rx_line1 = 1'b1;
    endtask

    task automatic pulse_line0(input int length);
        rx_line0 = 1'b0;
        repeat (length) @(negedge clk);
        rx_line0 = 1'b1;
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) @(negedge clk);
    endtask

    task automatic wait_drain(input int max_cycles);
        int n;
        n = 0;
        while ((exp_q0.size() != 0 || exp_q1.size() != 0) && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        assert (exp_q0.size() == 0 && exp_q1.size() == 0) else begin
            other_errors++;
            $display("Expected events did not come out within %0d cycles", max_cycles);
        end
    endtask

    // Outputs are sampled on the falling edge half a cycle after they change
    always @(negedge clk) begin
        logic [dual_uart_pkg::data_bits:0] exp_ev;
        logic have_exp;
        logic exp_err;
        if (!reset && (byte_valid || frame_error)) begin
            have_exp = byte_channel ? (exp_q1.size() > 0) : (exp_q0.size() > 0);
            assert (have_exp) else begin
                other_errors++;
                $display("An event came out on channel %0d at %0t with no frame outstanding",
                         byte_channel, $time);
            end
            if (byte_channel) begin
                last_cycle1 = cycle_count;
            end else begin
                last_cycle0 = cycle_count;
            end
            if (have_exp) begin
                if (byte_channel) begin
                    exp_ev = exp_q1.pop_front();
                end else begin
                    exp_ev = exp_q0.pop_front();
                end
                exp_err = exp_ev[dual_uart_pkg::data_bits];
                assert (byte_valid == !exp_err && frame_error == exp_err) else begin
                    kind_errors++;
                    $display("ERR %0t: channel %0d gave byte_valid %0b frame_error %0b, expected %s",
                             $time, byte_channel, byte_valid, frame_error,
                             exp_err ? "frame_error" : "byte_valid");
                end
                if (byte_valid && !exp_err) begin
                    assert (byte_data == exp_ev[dual_uart_pkg::data_bits-1:0]) else begin
                        data_errors++;
                        $display("ERR %0t: channel %0d byte 0x%02h, expected 0x%02h", $time,
                                 byte_channel, byte_data,
                                 exp_ev[dual_uart_pkg::data_bits-1:0]);
                    end
                end
            end
        end
    end

    initial begin
        #(timeout_ns);
        $display("Timeout after %0d ns, the run did not finish", timeout_ns);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        reset    = 1'b1;
        rx_line0 = 1'b1;
        rx_line1 = 1'b1;
        for (int i = 0; i < num_random; i++) begin
            rand_data0[i] = 8'($random(seed));
            rand_data1[i] = 8'($random(seed));
            rand_gap0[i]  = {$random(seed)} % (2 * bit_cycles);  // Zero means back to back
            rand_gap1[i]  = {$random(seed)} % (2 * bit_cycles);
        end
        repeat (5) @(negedge clk);
        reset = 1'b0;
        idle_cycles(2 * bit_cycles);

        // Single bytes on each line
        drive_line0(8'ha5, 1'b1, 0);
        wait_drain(2 * bit_cycles);
        drive_line1(8'h3c, 1'b1, 7);
        wait_drain(2 * bit_cycles);
        idle_cycles(bit_cycles);

        // Same start cycle on both lines collides in the merge
        fork
            drive_line0(8'h81, 1'b1, 0);
            drive_line1(8'h7e, 1'b1, 0);
        join
        wait_drain(2 * bit_cycles);
        assert (last_cycle1 == last_cycle0 + 1) else begin
            order_errors++;
            $display("ERR %0t: clash gave channel 0 at cycle %0d and channel 1 at cycle %0d",
                     $time, last_cycle0, last_cycle1);
        end
        idle_cycles(bit_cycles);

        // Low stop bits
        drive_line0(8'h5a, 1'b0, 0);
        idle_cycles(3 * bit_cycles);
        drive_line1(8'hc3, 1'b0, 11);
        idle_cycles(3 * bit_cycles);
        wait_drain(2 * bit_cycles);

        // A short low pulse must be rejected at the start bit centre
        pulse_line0(bit_cycles / 2 - 16);
        idle_cycles(2 * bit_cycles);
        drive_line0(8'h96, 1'b1, 0);
        wait_drain(2 * bit_cycles);
        idle_cycles(bit_cycles);

        fork
            begin
                for (int i = 0; i < num_random; i++) begin
                    drive_line0(rand_data0[i], 1'b1, rand_gap0[i]);
                end
            end
            begin
                for (int i = 0; i < num_random; i++) begin
                    drive_line1(rand_data1[i], 1'b1, rand_gap1[i]);
                end
            end
        join
        wait_drain(2 * bit_cycles);
        idle_cycles(2 * bit_cycles);

        assert (exp_q0.size() == 0 && exp_q1.size() == 0) else begin
            other_errors++;
            $display("Frames were still waiting for their events at the end of the run");
        end
        $display("Errors: kind %0d, data %0d, order %0d, other %0d",
                 kind_errors, data_errors, order_errors, other_errors);
        if (kind_errors + data_errors + order_errors + other_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- rtl/dual_uart_pkg.sv
package dual_uart_pkg;

    localparam logic [31:0] clk_freq  = 32'd250_000_000;  // System clock in Hz
    localparam logic [31:0] baud_rate = 32'd3_125_000;    // Serial line rate in bit/s
    localparam int oversample = 4;                       // Ticks per bit
    localparam int data_bits  = 8;                       // Payload bits per frame

    // Clock cycles between two oversample ticks, 20 at the rates above
    localparam int div_counter = clk_freq / (baud_rate * 32'(oversample));

    localparam int mid_sample = oversample / 2;  // Tick index of the bit centre

    // Counter widths derived from the rates
    localparam int tick_count_width   = $clog2(div_counter);
    localparam int sample_count_width = $clog2(oversample);
    localparam int bit_count_width    = $clog2(data_bits);

    // Receiver FSM states
    typedef enum logic [1:0] {
        rx_idle,   // Waiting for a falling edge
        rx_start,  // Validating the start bit
        rx_data,   // Shifting in data bits
        rx_stop    // Checking the stop bit
    } rx_state_t;

endpackage

//--- rtl/dual_uart_rx_top.sv
`timescale 1ns/100ps

// Two-line UART receive front end
module dual_uart_rx_top (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               rx_line0,
    input  logic                               rx_line1,
    output logic                               byte_valid,
    output logic [dual_uart_pkg::data_bits-1:0] byte_data,
    output logic                               byte_channel,
    output logic                               frame_error
);

    logic tick;  // Shared sample grid

    logic                               done0;
    logic [dual_uart_pkg::data_bits-1:0] data0;
    logic                               ferr0;

    logic                               done1;
    logic [dual_uart_pkg::data_bits-1:0] data1;
    logic                               ferr1;

    oversample_tick u_tick (
        .clk   (clk),
        .reset (reset),
        .tick  (tick)
    );

    uart_rx_channel ch0 (
        .clk     (clk),
        .reset   (reset),
        .tick    (tick),
        .rx_line (rx_line0),
        .done    (done0),
        .data    (data0),
        .ferr    (ferr0)
    );

    uart_rx_channel ch1 (
        .clk     (clk),
        .reset   (reset),
        .tick    (tick),
        .rx_line (rx_line1),
        .done    (done1),
        .data    (data1),
        .ferr    (ferr1)
    );

    rx_merge u_merge (
        .clk          (clk),
        .reset        (reset),
        .done0        (done0),
        .data0        (data0),
        .ferr0        (ferr0),
        .done1        (done1),
        .data1        (data1),
        .ferr1        (ferr1),
        .byte_valid   (byte_valid),
        .byte_data    (byte_data),
        .byte_channel (byte_channel),
        .frame_error  (frame_error)
    );

endmodule

//--- rtl/oversample_tick.sv
`timescale 1ns/100ps

// Common sample grid for both receive channels
module oversample_tick (
    input  logic clk,
    input  logic reset,
    output logic tick
);

    logic [dual_uart_pkg::tick_count_width-1:0] count;  // Cycles since the last tick

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
            tick  <= 1'b0;
        end else begin
            if (count == dual_uart_pkg::div_counter - 1) begin
                count <= '0;                             // Wrap and start the next period
                tick  <= 1'b1;                           // One pulse per period
            end else begin
                count <= count + 1'b1;
                tick  <= 1'b0;
            end
        end
    end

    // The period is well above two cycles, so a tick never lasts longer than one clock
    a_tick_single_cycle : assert property (
        @(posedge clk) disable iff (reset)
        tick |=> !tick
    );

endmodule

//--- rtl/rx_merge.sv
`timescale 1ns/100ps

// Merges the events of two channels into one tagged stream, channel 0 first
module rx_merge (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               done0,
    input  logic [dual_uart_pkg::data_bits-1:0] data0,
    input  logic                               ferr0,
    input  logic                               done1,
    input  logic [dual_uart_pkg::data_bits-1:0] data1,
    input  logic                               ferr1,
    output logic                               byte_valid,
    output logic [dual_uart_pkg::data_bits-1:0] byte_data,
    output logic                               byte_channel,
    output logic                               frame_error
);

    logic ev0;  // Channel 0 reports something this cycle
    logic ev1;  // Channel 1 reports something this cycle

    logic                               pend_valid;  // Channel 1 event waiting for its slot
    logic                               pend_err;    // Waiting event is a framing error
    logic [dual_uart_pkg::data_bits-1:0] pend_data;

    logic take0;     // Output slot goes to channel 0
    logic take_pend; // Output slot goes to the pending entry
    logic take1;     // Output slot goes straight to channel 1

    assign ev0 = done0 || ferr0;
    assign ev1 = done1 || ferr1;

    assign take0     = ev0;
    assign take_pend = !ev0 && pend_valid;
    assign take1     = !ev0 && !pend_valid && ev1;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            byte_valid  <= 1'b0;
            frame_error <= 1'b0;
            pend_valid  <= 1'b0;
        end else begin
            byte_valid  <= (take0 && done0) || (take_pend && !pend_err) || (take1 && done1);
            frame_error <= (take0 && ferr0) || (take_pend && pend_err) || (take1 && ferr1);
            if (take0 && ev1) begin
                pend_valid <= 1'b1;                      // Clash, channel 1 goes next cycle
            end else if (take_pend) begin
                pend_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take0) begin
            byte_data    <= data0;
            byte_channel <= 1'b0;
        end else if (take_pend) begin
            byte_data    <= pend_data;
            byte_channel <= 1'b1;
        end else if (take1) begin
            byte_data    <= data1;
            byte_channel <= 1'b1;
        end

        if (take0 && ev1) begin
            pend_data <= data1;
            pend_err  <= ferr1;
        end
    end

    // Channel events are a bit time apart, so the single entry is always free in time
    a_pending_free : assert property (
        @(posedge clk) disable iff (reset)
        pend_valid |-> !(done1 || ferr1)
    );

    a_out_exclusive : assert property (
        @(posedge clk) disable iff (reset)
        !(byte_valid && frame_error)
    );

endmodule

//--- rtl/uart_rx_channel.sv
`timescale 1ns/100ps

// One UART receiver, 8N1, oversampled at four ticks per bit
module uart_rx_channel (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               tick,
    input  logic                               rx_line,
    output logic                               done,
    output logic [dual_uart_pkg::data_bits-1:0] data,
    output logic                               ferr
);

    dual_uart_pkg::rx_state_t state;

    logic rx_meta;  // First synchronizer stage
    logic rx_sync;  // Line value as seen by the FSM

    logic [dual_uart_pkg::sample_count_width-1:0] sample_cnt;  // Tick index inside a bit
    logic [dual_uart_pkg::bit_count_width-1:0]    bit_cnt;     // Data bit index
    logic [dual_uart_pkg::data_bits-1:0]          shift_reg;   // LSB arrives first

    logic mid_tick;  // Tick at the sample point of the current bit
    logic end_tick;  // Last tick of the current bit

    assign mid_tick = tick && (sample_cnt == dual_uart_pkg::mid_sample - 1);
    assign end_tick = tick && (sample_cnt == dual_uart_pkg::oversample - 1);

    assign data = shift_reg;  // Stable through the stop bit, so valid with done

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rx_meta <= 1'b1;  // Idle level, so reset release never looks like a start bit
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx_line;
            rx_sync <= rx_meta;
        end
    end

    // The FSM only moves on a tick; done and ferr are cleared on every other cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= dual_uart_pkg::rx_idle;
            sample_cnt <= '0;
            bit_cnt    <= '0;
            done       <= 1'b0;
            ferr       <= 1'b0;
        end else begin
            done <= 1'b0;
            ferr <= 1'b0;
            if (tick) begin
                if (state == dual_uart_pkg::rx_idle || end_tick) begin
                    sample_cnt <= '0;                    // Next tick is index 0 of a new bit
                end else begin
                    sample_cnt <= sample_cnt + 1'b1;
                end

                case (state)
                    dual_uart_pkg::rx_idle: begin
                        if (!rx_sync) begin
                            state <= dual_uart_pkg::rx_start;  // Possible start bit
                        end
                    end
                    dual_uart_pkg::rx_start: begin
                        if (mid_tick && rx_sync) begin
                            state <= dual_uart_pkg::rx_idle;   // Glitch, not a real start bit
                        end else if (end_tick) begin
                            state   <= dual_uart_pkg::rx_data;
                            bit_cnt <= '0;
                        end
                    end
                    dual_uart_pkg::rx_data: begin
                        if (end_tick) begin
                            if (bit_cnt == dual_uart_pkg::data_bits - 1) begin
                                state <= dual_uart_pkg::rx_stop;
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                            end
                        end
                    end
                    dual_uart_pkg::rx_stop: begin
                        if (mid_tick) begin
                            done <= rx_sync;             // Good stop bit
                            ferr <= !rx_sync;            // Stop bit low, framing error
                        end
                        // A low line here is already the next start bit of a
                        // back-to-back frame, so take it on this tick and keep the grid phase
                        if (end_tick) begin
                            state <= rx_sync ? dual_uart_pkg::rx_idle
                                             : dual_uart_pkg::rx_start;
                        end
                    end
                    default: begin
                        state <= dual_uart_pkg::rx_idle;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mid_tick && state == dual_uart_pkg::rx_data) begin
            shift_reg <= {rx_sync, shift_reg[dual_uart_pkg::data_bits-1:1]};  // Shift right
        end
    end

    // The merge relies on a channel reporting one event per cycle at most
    a_done_ferr_exclusive : assert property (
        @(posedge clk) disable iff (reset)
        !(done && ferr)
    );

    // Events come from the sample point, which always falls on a tick
    a_event_after_tick : assert property (
        @(posedge clk) disable iff (reset)
        (done || ferr) |-> $past(tick)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds the dual_uart_rx testbench with Verilator and runs it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_dual_uart_rx \
    -f dual_uart_rx.f -o tb_dual_uart_rx &&
./obj_dir/tb_dual_uart_rx | tee /dev/stderr | grep -qx "TESTBENCH PASSED" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
